/* vc_link_cfg_pkg.sv */
`default_nettype none

// ------------------------------------------------------------------------
// sizing and timing constants shared by both ends of the link
// ------------------------------------------------------------------------

package vc_link_cfg_pkg;

  // width of one data word on both ready/ready ports
  localparam int word_width = 8;

  // receiver buffer entries, also the number of credits granted at wakeup
  localparam int fifo_depth = 4;
  localparam int fifo_ptr_sz = $clog2(fifo_depth);

  // credit counter width, wide enough to hold fifo_depth
  localparam int cc_sz = 3;

  // cycles between wakeup pattern pairs while the sender waits for a credit
  // this has to be longer than the full round trip through the channel
  localparam int wakeup_interval = 32;
  localparam int wake_cnt_sz = $clog2(wakeup_interval);

  // first wakeup word, the second one is its bitwise inverse
  localparam logic [word_width-1:0] wakeup_pattern = 8'h5a;

  // register stages in each direction of the channel
  localparam int channel_stages = 2;

endpackage

`default_nettype wire

/* vc_link_types_pkg.sv */
`default_nettype none

// ------------------------------------------------------------------------
// bundles and state encodings used on and around the link
// ------------------------------------------------------------------------

package vc_link_types_pkg;

  import vc_link_cfg_pkg::*;

  // one word on the forward channel
  // data only means something in a cycle where vld is high
  typedef struct packed {
    logic                  vld;
    logic [word_width-1:0] data;
  } flit_t;

  // payload of a ready/ready port
  typedef struct packed {
    logic [word_width-1:0] data;
  } sd_word_t;

  // sender controller
  // s_init waits for the first credit, the two wake states send the pattern pair
  typedef enum logic [1:0] {
    s_init,
    s_run,
    s_wake0,
    s_wake1
  } sender_state_t;

  // receiver controller, pattern detect then credit grant then normal traffic
  typedef enum logic [1:0] {
    r_idle,
    r_saw0,
    r_grant,
    r_run
  } receiver_state_t;

endpackage

`default_nettype wire

/* vc_sender.sv */
`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------------------------------
// ready/ready to valid/credit conversion on the producer side of the link
// ------------------------------------------------------------------------

module vc_sender
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        c_srdy,
  output logic                        c_drdy,
  input  vc_link_types_pkg::sd_word_t c_word,
  output vc_link_types_pkg::flit_t    tx_flit,
  input  logic                        tx_cr
);

  import vc_link_cfg_pkg::*;
  import vc_link_types_pkg::*;

  sender_state_t          state;
  sender_state_t          nxt_state;
  logic [cc_sz-1:0]       cc;
  logic [cc_sz-1:0]       nxt_cc;
  logic [wake_cnt_sz-1:0] wake_cnt;
  logic [wake_cnt_sz-1:0] nxt_wake_cnt;
  logic                   tx_vld;
  logic                   nxt_vld;
  logic [word_width-1:0]  tx_data;
  logic [word_width-1:0]  nxt_data;

  // ------------------------------------------------------------------------
  // next state, credit and wake counter logic
  // ------------------------------------------------------------------------

  always_comb
  begin
    nxt_state    = state;
    nxt_cc       = cc;
    nxt_wake_cnt = wake_cnt;
    nxt_vld      = 1'b0;
    nxt_data     = c_word.data;
    c_drdy       = 1'b0;

    case (state)
      s_init:
      begin
        // the first returned credit proves the receiver saw the pattern
        // and it is worth exactly one credit here
        if (tx_cr)
        begin
          nxt_state = s_run;
          nxt_cc    = cc_sz'(1);
        end
        else if (wake_cnt == wake_cnt_sz'(wakeup_interval - 1))
          nxt_state = s_wake0;
        nxt_wake_cnt = wake_cnt + 1'b1;
      end

      s_run:
      begin
        // the input is only ready while a credit is in hand
        c_drdy  = (cc != '0);
        nxt_vld = c_drdy & c_srdy;
        // a send and a credit in the same cycle cancel out
        if (nxt_vld && !tx_cr)
          nxt_cc = cc - 1'b1;
        else if (tx_cr && !nxt_vld && (cc != {cc_sz{1'b1}}))
          nxt_cc = cc + 1'b1;
      end

      s_wake0:
      begin
        nxt_vld   = 1'b1;
        nxt_data  = wakeup_pattern;
        nxt_state = s_wake1;
      end

      s_wake1:
      begin
        nxt_vld      = 1'b1;
        nxt_data     = ~wakeup_pattern;
        nxt_wake_cnt = '0;
        nxt_state    = s_init;
      end

      default:
        nxt_state = s_init;
    endcase
  end

  // ------------------------------------------------------------------------
  // registers
  // ------------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= s_init;
      cc       <= '0;
      wake_cnt <= '0;
      tx_vld   <= 1'b0;
    end
    else
    begin
      state    <= nxt_state;
      cc       <= nxt_cc;
      wake_cnt <= nxt_wake_cnt;
      tx_vld   <= nxt_vld;
    end
  end

  // payload only moves when a word actually goes out on the channel
  always_ff @(posedge clk)
  begin
    if (nxt_vld)
      tx_data <= nxt_data;
  end

  assign tx_flit = '{vld: tx_vld, data: tx_data};

endmodule

`default_nettype wire

/* vc_channel_delay.sv */
`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------------------------------
// fixed register delay standing in for a long route between the two ends
// ------------------------------------------------------------------------

module vc_channel_delay
(
  input  logic                     clk,
  input  logic                     reset,
  input  vc_link_types_pkg::flit_t in_flit,
  output vc_link_types_pkg::flit_t out_flit,
  input  logic                     in_cr,
  output logic                     out_cr
);

  import vc_link_cfg_pkg::*;

  logic [channel_stages-1:0] vld_q;
  logic [channel_stages-1:0] cr_q;
  logic [word_width-1:0]     data_q [channel_stages];

  // qualifier bits in both directions are cleared so nothing stale leaks out
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      vld_q <= '0;
      cr_q  <= '0;
    end
    else
    begin
      vld_q[0] <= in_flit.vld;
      cr_q[0]  <= in_cr;
      for (int i = 1; i < channel_stages; i++)
      begin
        vld_q[i] <= vld_q[i-1];
        cr_q[i]  <= cr_q[i-1];
      end
    end
  end

  // data rides alongside vld and is ignored whenever vld is low
  always_ff @(posedge clk)
  begin
    data_q[0] <= in_flit.data;
    for (int i = 1; i < channel_stages; i++)
      data_q[i] <= data_q[i-1];
  end

  assign out_flit = '{vld: vld_q[channel_stages-1], data: data_q[channel_stages-1]};
  assign out_cr   = cr_q[channel_stages-1];

endmodule

`default_nettype wire

/* vc_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------------------------------
// valid/credit back to ready/ready on the consumer side of the link
// ------------------------------------------------------------------------

module vc_receiver
(
  input  logic                        clk,
  input  logic                        reset,
  input  vc_link_types_pkg::flit_t    rx_flit,
  output logic                        rx_cr,
  output logic                        p_srdy,
  input  logic                        p_drdy,
  output vc_link_types_pkg::sd_word_t p_word
);

  import vc_link_cfg_pkg::*;
  import vc_link_types_pkg::*;

  receiver_state_t        state;
  receiver_state_t        nxt_state;
  logic [cc_sz-1:0]       grant_cnt;
  logic [cc_sz-1:0]       nxt_grant_cnt;
  logic                   grant_cr;
  logic                   enq;
  logic                   deq;
  logic [fifo_ptr_sz-1:0] wr_ptr;
  logic [fifo_ptr_sz-1:0] rd_ptr;
  logic [cc_sz-1:0]       count;
  logic [word_width-1:0]  mem [fifo_depth];

  // ------------------------------------------------------------------------
  // wakeup detection and initial credit grant
  // ------------------------------------------------------------------------

  always_comb
  begin
    nxt_state     = state;
    nxt_grant_cnt = grant_cnt;
    grant_cr      = 1'b0;

    case (state)
      r_idle:
      begin
        if (rx_flit.vld && (rx_flit.data == wakeup_pattern))
          nxt_state = r_saw0;
      end

      r_saw0:
      begin
        // the inverse has to follow on the very next cycle
        if (rx_flit.vld && (rx_flit.data == ~wakeup_pattern))
        begin
          nxt_state     = r_grant;
          nxt_grant_cnt = '0;
        end
        else
          nxt_state = r_idle;
      end

      r_grant:
      begin
        // one credit per cycle until the whole buffer has been offered
        grant_cr = 1'b1;
        if (grant_cnt == cc_sz'(fifo_depth - 1))
          nxt_state = r_run;
        else
          nxt_grant_cnt = grant_cnt + 1'b1;
      end

      r_run:
        nxt_state = r_run;

      default:
        nxt_state = r_idle;
    endcase
  end

  // every flit in r_run is data, anything earlier never reaches the buffer
  assign enq = (state == r_run) && rx_flit.vld;
  assign deq = p_srdy && p_drdy;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= r_idle;
      grant_cnt <= '0;
      rx_cr     <= 1'b0;
    end
    else
    begin
      state     <= nxt_state;
      grant_cnt <= nxt_grant_cnt;
      // a freed entry goes back to the sender one cycle after the dequeue
      rx_cr     <= grant_cr | deq;
    end
  end

  // ------------------------------------------------------------------------
  // circular buffer
  // ------------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr <= (wr_ptr == fifo_ptr_sz'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (deq)
        rd_ptr <= (rd_ptr == fifo_ptr_sz'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({enq, deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the sender never holds more credits than there are free entries
  always_ff @(posedge clk)
  begin
    if (enq)
      mem[wr_ptr] <= rx_flit.data;
  end

  // head entry is read straight out, so it stays put until it is taken
  assign p_srdy = (count != '0);
  assign p_word = '{data: mem[rd_ptr]};

endmodule

`default_nettype wire

/* vc_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------------------------------
// sender, channel and receiver wired between the two ready/ready ports
// ------------------------------------------------------------------------

module vc_link_top
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        c_srdy,
  output logic                        c_drdy,
  input  vc_link_types_pkg::sd_word_t c_word,
  output logic                        p_srdy,
  input  logic                        p_drdy,
  output vc_link_types_pkg::sd_word_t p_word
);

  import vc_link_types_pkg::*;

  // forward words leaving the sender and arriving at the receiver
  flit_t tx_flit;
  flit_t rx_flit;

  // credits leaving the receiver and arriving back at the sender
  logic  rx_cr;
  logic  tx_cr;

  vc_sender sender
  (
    .clk     (clk),
    .reset   (reset),
    .c_srdy  (c_srdy),
    .c_drdy  (c_drdy),
    .c_word  (c_word),
    .tx_flit (tx_flit),
    .tx_cr   (tx_cr)
  );

  // both directions see the same number of stages
  vc_channel_delay channel
  (
    .clk      (clk),
    .reset    (reset),
    .in_flit  (tx_flit),
    .out_flit (rx_flit),
    .in_cr    (rx_cr),
    .out_cr   (tx_cr)
  );

  vc_receiver receiver
  (
    .clk     (clk),
    .reset   (reset),
    .rx_flit (rx_flit),
    .rx_cr   (rx_cr),
    .p_srdy  (p_srdy),
    .p_drdy  (p_drdy),
    .p_word  (p_word)
  );

endmodule

`default_nettype wire

/* vc_link_tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

// free running testbench clock, starts low and toggles every half period
module vc_link_tb_clock
#(
  parameter int period = 20
)
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
      #(period / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

/* vc_link_properties.sv */
`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------------------------------
// protocol checks on both ends of the link
// ------------------------------------------------------------------------

// one checker serves both ends, sender_side picks which checks are built
// and the inputs of the other side are tied off in the bind
module vc_link_properties
#(
  parameter bit sender_side = 1'b1
)
(
  input logic                                    clk,
  input logic                                    reset,
  input logic                                    snd_run,
  input logic [vc_link_cfg_pkg::cc_sz-1:0]       cc,
  input logic                                    vld,
  input logic [vc_link_cfg_pkg::cc_sz-1:0]       count,
  input logic                                    p_srdy,
  input logic                                    p_drdy,
  input logic [vc_link_cfg_pkg::word_width-1:0]  p_word
);

  import vc_link_cfg_pkg::*;

  if (sender_side)
  begin : g_sender
    // with an empty credit counter in run state nothing may go out next cycle
    no_send_without_credit: assert property (@(posedge clk) disable iff (reset)
      (snd_run && (cc == '0)) |=> !vld)
      else $error("sender issued a flit in run state without a credit");
  end
  else
  begin : g_receiver
    // the buffer only ever receives words the sender had credits for
    fifo_bound: assert property (@(posedge clk) disable iff (reset)
      count <= cc_sz'(fifo_depth))
      else $error("receiver FIFO holds more than %0d entries", fifo_depth);

    // a stalled head word has to hold still until the consumer takes it
    head_stable: assert property (@(posedge clk) disable iff (reset)
      (p_srdy && !p_drdy) |=> $stable(p_word))
      else $error("p_word changed while p_srdy was high and p_drdy low");
  end

endmodule

bind vc_sender vc_link_properties #(.sender_side(1'b1)) sender_props
(
  .clk     (clk),
  .reset   (reset),
  .snd_run (state == vc_link_types_pkg::s_run),
  .cc      (cc),
  .vld     (tx_flit.vld),
  .count   ('0),
  .p_srdy  (1'b0),
  .p_drdy  (1'b1),
  .p_word  ('0)
);

bind vc_receiver vc_link_properties #(.sender_side(1'b0)) receiver_props
(
  .clk     (clk),
  .reset   (reset),
  .snd_run (1'b0),
  .cc      ('0),
  .vld     (1'b0),
  .count   (count),
  .p_srdy  (p_srdy),
  .p_drdy  (p_drdy),
  .p_word  (p_word.data)
);

`default_nettype wire

/* vc_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------------------------------
// testbench for the credit link, random traffic with stalls on both sides
// ------------------------------------------------------------------------

module vc_link_tb;

  import vc_link_cfg_pkg::*;
  import vc_link_types_pkg::*;

  localparam int clk_period  = 20;
  localparam int num_words   = 200;
  // the first words run with both sides always ready
  localparam int quiet_words = 50;
  // one long output stall starts once this many words have come out
  localparam int stall_after = 120;
  localparam int long_stall  = 40;
  localparam int watchdog_cycles = wakeup_interval * 4 + num_words * 40;

  logic     clk;
  logic     reset;
  logic     c_srdy;
  logic     c_drdy;
  sd_word_t c_word;
  logic     p_srdy;
  logic     p_drdy;
  sd_word_t p_word;

  int seed;
  int cons_seed;
  int accepted_count;
  int delivered_count;
  int reset_edges;
  int run_edges;
  logic woke;
  logic stall_done;
  logic [word_width-1:0] stim [num_words];
  // words accepted on the input and not yet seen on the output
  logic [word_width-1:0] sent_q [$];

  vc_link_tb_clock #(.period(clk_period)) clock_gen (.clk(clk));

  vc_link_top uut
  (
    .clk    (clk),
    .reset  (reset),
    .c_srdy (c_srdy),
    .c_drdy (c_drdy),
    .c_word (c_word),
    .p_srdy (p_srdy),
    .p_drdy (p_drdy),
    .p_word (p_word)
  );

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("[FAIL] %0d ns %s: got %0h, expected %0h", $time, name, actual, expected);
      $display("Test failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic report_failure(input string what);
    $display("ERROR at %0d ns: %s", $time, what);
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  // every accepted word leaves once, unchanged and in acceptance order,
  // so the next word out must be the oldest one still waiting
  function automatic logic [word_width-1:0] expected_word();
    return sent_q[0];
  endfunction

  // ------------------------------------------------------------------------
  // reset, stimulus setup and end of run
  // ------------------------------------------------------------------------

  initial
  begin
    seed            = 32'h5d02d45f;
    cons_seed       = seed ^ 32'h0000ffff;
    accepted_count  = 0;
    delivered_count = 0;
    reset_edges     = 0;
    run_edges       = 0;
    woke            = 1'b0;
    stall_done      = 1'b0;
    reset           = 1'b1;
    c_srdy          = 1'b0;
    c_word          = '0;
    p_drdy          = 1'b0;
    for (int i = 0; i < num_words; i++)
      stim[i] = word_width'($random(seed));
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    wait (delivered_count == num_words);
    // p_drdy stays high from here on, so any stray extra output shows up
    // and every freed entry has time to travel back as a credit
    repeat (4 * wakeup_interval) @(posedge clk);
    // with all words drained the sender holds its credits again
    check_equal("c_drdy", 32'(c_drdy), 32'd1);
    $display("Test passed");
    $finish;
  end

  // producer holds each word until it is taken and idles on random cycles
  initial
  begin
    wait (reset === 1'b0);
    while (accepted_count < num_words)
    begin
      @(negedge clk);
      if (accepted_count < num_words)
      begin
        c_word.data = stim[accepted_count];
        c_srdy = (accepted_count < quiet_words) || (($random(seed) & 3) != 0);
      end
      else
        c_srdy = 1'b0;
    end
    @(negedge clk);
    c_srdy = 1'b0;
  end

  // consumer stalls on random cycles and once for a long stretch
  initial
  begin
    wait (reset === 1'b0);
    while (delivered_count < num_words)
    begin
      @(negedge clk);
      if (!stall_done && (delivered_count >= stall_after))
      begin
        p_drdy = 1'b0;
        repeat (long_stall) @(negedge clk);
        // with the buffer full and no credits coming back the input must close
        if (c_drdy)
          report_failure("c_drdy is still high at the end of a long p_drdy stall");
        stall_done = 1'b1;
      end
      if (delivered_count < quiet_words)
        p_drdy = 1'b1;
      else
        p_drdy = ($random(cons_seed) & 3) != 0;
    end
    // keep taking words so that anything left over in the buffer comes out
    @(negedge clk);
    p_drdy = 1'b1;
  end

  // ------------------------------------------------------------------------
  // compare process, samples both ports at the rising edge
  // ------------------------------------------------------------------------

  always @(posedge clk)
  begin
    if (reset)
    begin
      reset_edges++;
      // the first edge is the one that loads the reset values
      if (reset_edges > 1)
      begin
        check_equal("c_drdy", 32'(c_drdy), 32'd0);
        check_equal("p_srdy", 32'(p_srdy), 32'd0);
      end
    end
    else
    begin
      if (run_edges == 0)
      begin
        check_equal("c_drdy", 32'(c_drdy), 32'd0);
        check_equal("p_srdy", 32'(p_srdy), 32'd0);
      end
      run_edges++;
      if (c_drdy)
        woke = 1'b1;
      if (c_srdy && c_drdy)
      begin
        sent_q.push_back(c_word.data);
        accepted_count++;
      end
      if (p_srdy && p_drdy)
      begin
        // covers wakeup words leaking out as well as duplicated words
        if (!woke || (sent_q.size() == 0))
          report_failure("output transfer with no accepted word waiting");
        check_equal("p_word", 32'(p_word.data), 32'(expected_word()));
        void'(sent_q.pop_front());
        delivered_count++;
      end
      // words in flight plus buffered words can never exceed the credit pool
      if (sent_q.size() > fifo_depth)
        report_failure("more words are outstanding than the receiver has entries");
    end
  end

  initial
  begin
    #(watchdog_cycles * clk_period);
    report_failure($sformatf("run timed out with %0d of %0d words delivered",
                             delivered_count, num_words));
  end

endmodule

`default_nettype wire

/* verilog.f */
vc_link_cfg_pkg.sv
vc_link_types_pkg.sv
vc_sender.sv
vc_channel_delay.sv
vc_receiver.sv
vc_link_top.sv
vc_link_tb_clock.sv
vc_link_properties.sv
vc_link_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= vc_link_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Test passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
